// File: Bender.yml
package:
  name: softmax_exp_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/softmax_pkg.sv
      - verilog/fp_add.sv
      - verilog/softmax_input_buffer.sv
      - verilog/exp_lut.sv
      - verilog/exp_sum_accumulator.sv
      - verilog/softmax_exp_stage.sv
  - target: test
    include_dirs:
      - verilog
      - bench
    files:
      - bench/tb_softmax_exp_stage.sv

// File: bench/tb_softmax_tasks.svh
// reference float helpers and compare tasks for the softmax stage testbench
// included inside the testbench top after block_in is declared

`ifndef TB_SOFTMAX_TASKS_SVH
`define TB_SOFTMAX_TASKS_SVH

int pass_count = 0;
int fail_count = 0;

// real value of a word where 1.0 is exponent 0x81 with mantissa 0x100
function automatic real fp_to_real(input softmax_pkg::fp_word_t w);
    real mag;
    mag = real'(w.fields.mantissa) / 256.0 * (2.0 ** (real'(w.fields.exponent) - 129.0));
    return w.fields.sign ? -mag : mag;
endfunction

// exact values only since mantissa bits below the ninth are cut
function automatic softmax_pkg::fp_word_t real_to_fp(input real v);
    softmax_pkg::fp_word_t w;
    real                   mag;
    int                    e;
    w = '0;
    if (v == 0.0)
        return w;
    w.fields.sign = (v < 0.0);
    mag = (v < 0.0) ? -v : v;
    e   = 129;
    while (mag >= 2.0) begin
        mag = mag / 2.0;
        e++;
    end
    while (mag < 1.0) begin
        mag = mag * 2.0;
        e--;
    end
    w.fields.exponent = 8'(e);
    w.fields.mantissa = 9'($rtoi(mag * 256.0));   // leading one lands in bit 8
    return w;
endfunction

// largest element of the block by real value
function automatic softmax_pkg::fp_word_t ref_max();
    softmax_pkg::fp_word_t best;
    best = block_in[0];
    for (int i = 1; i < `SM_NUM; i++)
        if (fp_to_real(block_in[i]) > fp_to_real(best))
            best = block_in[i];
    return best;
endfunction

// address of a zero difference with sign 0 and half of 0x100 >> shift rounded up
function automatic logic [`SM_LUT_ADDR_W-1:0] zero_diff_addr(input int shift);
    int shifted;
    shifted = 256 >> shift;
    return `SM_LUT_ADDR_W'((shifted + 1) / 2);
endfunction

// table entry tagged by its index as a power of two so block sums stay exact
function automatic softmax_pkg::fp_word_t index_word(input int i);
    softmax_pkg::fp_word_t w;
    w.fields.sign     = i[8];
    w.fields.exponent = 8'(i) + 8'h30;     // wraps for top indices that are never read
    w.fields.mantissa = 9'h100;
    return w;
endfunction

task automatic check_fp(input softmax_pkg::fp_word_t got, input softmax_pkg::fp_word_t want,
                        input string what);
    if (got.raw !== want.raw) begin
        $display("** Error at %0t: %s is %h, expected %h", $time, what, got.raw, want.raw);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

task automatic check_result(input softmax_pkg::block_result_t got,
                            input softmax_pkg::block_result_t want, input string what);
    if (got !== want) begin
        $display("** Error at %0t: %s sum %h max %h, expected sum %h max %h", $time, what,
                 got.sum.raw, got.max.raw, want.sum.raw, want.max.raw);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

// counts, cycle distances and levels
task automatic check_count(input int got, input int want, input string what);
    if (got != want) begin
        $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, want);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

task automatic report_test(input string name, input int fails_before);
    if (fail_count == fails_before)
        $display("[%0t] %s: pass", $time, name);
    else
        $display("[%0t] %s: %0d failed checks", $time, name, fail_count - fails_before);
endtask

`endif

// File: bench/tb_softmax_exp_stage.sv
// directed testbench for the softmax exponent and sum stage
// compile with the project file list and run tb_softmax_exp_stage as top

`timescale 1ns/1ps
`include "softmax_defines.svh"

module tb_softmax_exp_stage;

    // per block allowance for pipeline, input, table load and slack
    localparam int watchdog_cycles = 40 * ((`SM_NUM + 4) + `SM_NUM + `SM_LUT_DEPTH + 8);
    localparam softmax_pkg::fp_word_t junk_word = {1'b0, 8'hf0, 9'h1ff};   // above any element

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic [`SM_SHIFT_W-1:0]     cfg_shift;
    softmax_pkg::lut_wr_t       lut_wr;
    softmax_pkg::fp_word_t      idata;
    logic                       idata_valid;
    softmax_pkg::fp_word_t      odata;
    logic                       odata_valid;
    softmax_pkg::block_result_t result;
    logic                       result_valid;
    logic                       busy;

    softmax_pkg::fp_word_t      block_in [`SM_NUM];
    softmax_pkg::fp_word_t      out_q [$];          // odata seen in this block
    softmax_pkg::block_result_t res_q [$];
    int                         cycle = 0;          // rising edges so far
    int                         acc_count;
    int                         drop_count;
    int                         last_acc;           // edge that took the last element
    int                         busy_rise;
    int                         res_at;
    int                         busy_at_res;
    logic                       busy_d = 1'b0;
    int unsigned                seed;

    `include "tb_softmax_tasks.svh"

    always #5 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    softmax_exp_stage uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_shift    (cfg_shift),
        .lut_wr       (lut_wr),
        .idata        (idata),
        .idata_valid  (idata_valid),
        .odata        (odata),
        .odata_valid  (odata_valid),
        .result       (result),
        .result_valid (result_valid),
        .busy         (busy)
    );

    ////////////////////////////////////////////////////////////////////////////
    // monitor on the falling edge where every output has settled
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n) begin
            if (idata_valid && !busy) begin
                acc_count++;
                last_acc = cycle + 1;        // taken on the next rising edge
            end
            if (idata_valid && busy)
                drop_count++;
            if (busy && !busy_d)
                busy_rise = cycle;
            busy_d = busy;
            if (odata_valid)
                out_q.push_back(odata);
            if (result_valid) begin
                res_q.push_back(result);
                res_at      = cycle;
                busy_at_res = busy;          // should have dropped on this edge
            end
        end
    end

    task automatic load_table(input bit by_index);
        for (int i = 0; i < `SM_LUT_DEPTH; i++) begin
            @(posedge clk);
            lut_wr.en   <= 1'b1;
            lut_wr.addr <= `SM_LUT_ADDR_W'(i);
            lut_wr.data <= by_index ? index_word(i) : real_to_fp(1.0);
        end
        @(posedge clk);
        lut_wr.en <= 1'b0;
    endtask

    // mode 0 mixed signs, 1 all negative, 2 one value repeated
    task automatic fill_block(input int mode);
        softmax_pkg::fp_word_t w;
        for (int i = 0; i < `SM_NUM; i++) begin
            if (mode != 2 || i == 0) begin
                w.fields.sign     = (mode == 1) ? 1'b1 : 1'($urandom);
                w.fields.exponent = 8'h78 + 8'($urandom_range(15, 0));
                w.fields.mantissa = {1'b1, 8'($urandom)};
            end
            block_in[i] = w;
        end
    endtask

    // sends the block plus junk strobes into the busy window and waits for the result
    task automatic run_block(input string name, input int junk, output bit ok);
        int waited;
        out_q.delete();
        res_q.delete();
        acc_count  = 0;
        drop_count = 0;
        waited     = 0;
        for (int i = 0; i < `SM_NUM + junk; i++) begin
            @(posedge clk);
            if (i < `SM_NUM)
                idata <= block_in[i];
            else
                idata <= junk_word;
            idata_valid <= 1'b1;
        end
        @(posedge clk);
        idata_valid <= 1'b0;
        while (res_q.size() == 0 && waited < 4 * `SM_NUM) begin
            @(posedge clk);
            waited++;
        end
        ok = (res_q.size() != 0);
        if (!ok) begin
            $display("%s: result_valid never came, gave up after %0d cycles", name, waited);
            fail_count++;
        end else begin
            repeat (`SM_NUM) @(posedge clk);   // room for stray extra pulses
            check_count(res_q.size(), 1, {name, " result pulses"});
            check_count(out_q.size(), `SM_NUM, {name, " odata pulses"});
            check_count(acc_count, `SM_NUM, {name, " accepted elements"});
            check_count(drop_count, junk, {name, " strobes dropped while busy"});
            check_count(busy_rise - last_acc, 0, {name, " busy rise after last input"});
            check_count(res_at - last_acc, `SM_NUM + 4, {name, " result latency"});
            check_count(busy_at_res, 0, {name, " busy at result"});
        end
    endtask

    // every exponent is the same so the sum is SM_NUM times it
    task automatic block_test(input string name, input int mode, input int junk,
                              input softmax_pkg::fp_word_t each);
        softmax_pkg::block_result_t want;
        bit                         ok;
        fill_block(mode);
        run_block(name, junk, ok);
        if (ok) begin
            foreach (out_q[i])
                check_fp(out_q[i], each, {name, " odata"});
            want.sum = real_to_fp(real'(`SM_NUM) * fp_to_real(each));
            want.max = ref_max();
            check_result(res_q[0], want, {name, " result"});
        end
    endtask

    task automatic test_constant_table();
        int fails;
        fails = fail_count;
        load_table(1'b0);
        block_test("constant table", 0, 0, real_to_fp(1.0));
        report_test("constant table", fails);
    endtask

    task automatic test_block_max();
        int fails;
        fails = fail_count;
        load_table(1'b0);
        block_test("max mixed a", 0, 0, real_to_fp(1.0));
        block_test("max mixed b", 0, 0, real_to_fp(1.0));
        block_test("max all negative", 1, 0, real_to_fp(1.0));
        report_test("block maximum", fails);
    endtask

    // equal elements give a zero difference and the address depends on shift alone
    task automatic test_address_map(input int shift);
        int    fails;
        string name;
        fails = fail_count;
        name  = $sformatf("address map shift %0d", shift);
        load_table(1'b1);
        @(posedge clk);
        cfg_shift <= `SM_SHIFT_W'(shift);
        block_test(name, 2, 0, index_word(int'(zero_diff_addr(shift))));
        report_test(name, fails);
    endtask

    task automatic test_busy_latency();
        int fails;
        fails = fail_count;
        load_table(1'b0);
        block_test("busy with junk", 0, 3, real_to_fp(1.0));
        block_test("busy next block", 0, 0, real_to_fp(1.0));
        report_test("busy and latency", fails);
    endtask

    initial begin
        seed        = $urandom(32'hf088);
        rst_n       = 1'b0;
        cfg_shift   = '0;
        lut_wr      = '0;
        idata       = '0;
        idata_valid = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_constant_table();
        test_block_max();
        test_address_map(0);
        test_address_map(1);
        test_address_map(3);
        test_address_map(7);
        test_address_map(8);
        test_address_map(9);
        test_busy_latency();
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin
        #(watchdog_cycles * 10);
        $display("watchdog: run still going after %0d cycles, DUT or test hung",
                 watchdog_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: project.f
+incdir+verilog
+incdir+bench
verilog/softmax_pkg.sv
verilog/fp_add.sv
verilog/softmax_input_buffer.sv
verilog/exp_lut.sv
verilog/exp_sum_accumulator.sv
verilog/softmax_exp_stage.sv
bench/tb_softmax_exp_stage.sv

// File: verilog/exp_lut.sv
// exponent lookup: maps a float difference to a table address and reads
// the exponent word; the write port loads the table while the stage is idle

`timescale 1ns/1ps
`include "softmax_defines.svh"

module exp_lut (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`SM_SHIFT_W-1:0]  cfg_shift,
    input  softmax_pkg::lut_wr_t    lut_wr,
    input  softmax_pkg::fp_word_t   diff,
    input  logic                    diff_valid,
    output softmax_pkg::fp_word_t   exp_value,
    output logic                    exp_valid
);

    logic [`SM_FP_W-1:0]       lut_mem [`SM_LUT_DEPTH];
    logic [`SM_MAN_W-1:0]      man_full;    // leading one forced
    logic [`SM_MAN_W-1:0]      man_shift;
    logic [`SM_LUT_ADDR_W-2:0] man_round;
    logic [`SM_LUT_ADDR_W-1:0] addr_c;
    logic [`SM_LUT_ADDR_W-1:0] addr_q;
    logic [`SM_LUT_ADDR_W-1:0] ram_addr;
    logic                      addr_valid;

    ////////////////////////////////////////////////////////////////////////////
    // float to address
    ////////////////////////////////////////////////////////////////////////////
    assign man_full  = {1'b1, diff.fields.mantissa[`SM_MAN_W-2:0]};
    assign man_shift = man_full >> cfg_shift;
    // upper 8 bits plus the dropped lsb, wraps on all ones
    assign man_round = man_shift[`SM_MAN_W-1:1]
                     + {{(`SM_LUT_ADDR_W-2){1'b0}}, man_shift[0]};
    assign addr_c    = {diff.fields.sign, man_round};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            addr_valid <= 1'b0;
        else
            addr_valid <= diff_valid;
    end

    always_ff @(posedge clk) begin
        if (diff_valid)
            addr_q <= addr_c;
    end

    ////////////////////////////////////////////////////////////////////////////
    // single port table, write wins the address
    ////////////////////////////////////////////////////////////////////////////
    assign ram_addr = lut_wr.en ? lut_wr.addr : addr_q;

    always_ff @(posedge clk) begin
        if (lut_wr.en)
            lut_mem[ram_addr] <= lut_wr.data.raw;
        else if (addr_valid)
            exp_value.raw <= lut_mem[ram_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            exp_valid <= 1'b0;
        else
            exp_valid <= addr_valid && !lut_wr.en;   // read lost on a write
    end

endmodule

// File: verilog/exp_sum_accumulator.sv
// serial float sum of the streamed exponents of one block
// pulses result_valid after the SM_NUM-th exponent with sum and block max

`timescale 1ns/1ps
`include "softmax_defines.svh"

module exp_sum_accumulator (
    input  logic                       clk,
    input  logic                       rst_n,
    input  softmax_pkg::fp_word_t      exp_value,
    input  logic                       exp_valid,
    input  softmax_pkg::fp_word_t      max_value,
    output softmax_pkg::block_result_t result,
    output logic                       result_valid
);

    softmax_pkg::fp_word_t sum_q;
    softmax_pkg::fp_word_t max_q;
    softmax_pkg::fp_word_t acc_in;     // zero on the block's first exponent
    softmax_pkg::fp_word_t add_out;
    logic [`SM_PTR_W-1:0]  cnt;
    logic                  last_exp;

    assign acc_in   = (cnt == '0) ? '0 : sum_q;
    assign last_exp = exp_valid && (cnt == `SM_PTR_W'(`SM_NUM - 1));

    fp_add u_acc_add (
        .a   (exp_value),
        .b   (acc_in),
        .sum (add_out)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= last_exp;
            if (exp_valid)
                cnt <= cnt + 1'b1;     // back to 0 after the last one
        end
    end

    always_ff @(posedge clk) begin
        if (exp_valid)
            sum_q <= add_out;
        if (last_exp)
            max_q <= max_value;        // still stable, next block not started
    end

    assign result.sum = sum_q;
    assign result.max = max_q;

endmodule

// File: verilog/fp_add.sv
// combinational float adder for the 18 bit softmax format
// feed b with its sign flipped to subtract; no rounding, no special values

`timescale 1ns/1ps
`include "softmax_defines.svh"

module fp_add (
    input  softmax_pkg::fp_word_t a,
    input  softmax_pkg::fp_word_t b,
    output softmax_pkg::fp_word_t sum
);

    softmax_pkg::fp_fields_t big_op;     // larger magnitude operand
    softmax_pkg::fp_fields_t sml_op;     // smaller magnitude operand
    logic [`SM_EXP_W-1:0]    ediff;
    logic [`SM_MAN_W:0]      sml_align;  // extra top bit for carry out
    logic [`SM_MAN_W:0]      raw;        // unnormalized result
    logic [3:0]              lz;         // 0..9 leading zeros

    // count zeros above the first one
    function automatic logic [3:0] lead_zeros(input logic [`SM_MAN_W-1:0] m);
        logic [3:0] n;
        logic       hit;
        n   = 4'd0;
        hit = 1'b0;
        for (int i = `SM_MAN_W - 1; i >= 0; i--) begin
            if (m[i])
                hit = 1'b1;
            else if (!hit)
                n = n + 4'd1;
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // order operands by magnitude
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        if ({a.fields.exponent, a.fields.mantissa} > {b.fields.exponent, b.fields.mantissa}) begin
            big_op = a.fields;
            sml_op = b.fields;
        end else begin
            big_op = b.fields;   // ties land here, sign then follows b
            sml_op = a.fields;
        end
    end

    assign ediff     = big_op.exponent - sml_op.exponent;
    assign sml_align = {1'b0, sml_op.mantissa} >> ediff;

    ////////////////////////////////////////////////////////////////////////////
    // add or subtract, then normalize
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        sum = '0;
        raw = '0;
        lz  = '0;
        if (!a.fields.mantissa[`SM_MAN_W-1]) begin
            sum = b;                          // a is zero
        end else if (!b.fields.mantissa[`SM_MAN_W-1]) begin
            sum = a;                          // b is zero
        end else if (ediff > `SM_MAN_W) begin
            sum.fields = big_op;              // smaller one shifts out entirely
        end else if (big_op.sign == sml_op.sign) begin
            raw = {1'b0, big_op.mantissa} + sml_align;
            sum.fields.sign = big_op.sign;
            if (raw[`SM_MAN_W]) begin         // carry, shift right once
                sum.fields.exponent = big_op.exponent + 1'b1;
                sum.fields.mantissa = raw[`SM_MAN_W:1];
            end else begin
                sum.fields.exponent = big_op.exponent;
                sum.fields.mantissa = raw[`SM_MAN_W-1:0];
            end
        end else begin
            raw = {1'b0, big_op.mantissa} - sml_align;   // never negative
            if (raw == '0) begin
                sum = '0;                     // exact cancellation, +0
            end else begin
                lz = lead_zeros(raw[`SM_MAN_W-1:0]);
                sum.fields.sign     = big_op.sign;
                sum.fields.exponent = big_op.exponent - lz;   // wraps on underflow
                sum.fields.mantissa = raw[`SM_MAN_W-1:0] << lz;
            end
        end
    end

endmodule

// File: verilog/softmax_defines.svh
// widths and sizes shared by the softmax exponent stage
// include in any file that needs a field width or the block length

`ifndef SOFTMAX_DEFINES_SVH
`define SOFTMAX_DEFINES_SVH

// float word: sign, exponent, mantissa with explicit leading one
`define SM_FP_W        18
`define SM_EXP_W       8
`define SM_MAN_W       9

// block sequencing
`define SM_NUM         8    // elements per block
`define SM_PTR_W       3    // log2 of SM_NUM

// exponent lookup table
`define SM_LUT_ADDR_W  9    // sign + 8 rounded mantissa bits
`define SM_LUT_DEPTH   512
`define SM_SHIFT_W     8    // cfg_shift width

`endif

// File: verilog/softmax_exp_stage.sv
// top of the softmax exponent and sum stage
// buffer -> subtract max -> table lookup -> accumulate; busy blocks new input

`timescale 1ns/1ps
`include "softmax_defines.svh"

module softmax_exp_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`SM_SHIFT_W-1:0]     cfg_shift,    // static
    input  softmax_pkg::lut_wr_t       lut_wr,       // only while busy is low
    input  softmax_pkg::fp_word_t      idata,
    input  logic                       idata_valid,
    output softmax_pkg::fp_word_t      odata,
    output logic                       odata_valid,
    output softmax_pkg::block_result_t result,
    output logic                       result_valid,
    output logic                       busy
);

    softmax_pkg::fp_word_t rd_data;
    softmax_pkg::fp_word_t max_value;
    softmax_pkg::fp_word_t neg_max;
    softmax_pkg::fp_word_t diff_c;
    softmax_pkg::fp_word_t diff_q;
    logic                  rd_valid;
    logic                  diff_valid;

    softmax_input_buffer u_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .idata       (idata),
        .idata_valid (idata_valid),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid),
        .max_value   (max_value),
        .busy        (busy)
    );

    ////////////////////////////////////////////////////////////////////////////
    // element - max, one register stage
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        neg_max = max_value;
        neg_max.fields.sign = ~max_value.fields.sign;
    end

    fp_add u_sub (
        .a   (rd_data),
        .b   (neg_max),
        .sum (diff_c)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            diff_valid <= 1'b0;
        else
            diff_valid <= rd_valid;
    end

    always_ff @(posedge clk) begin
        if (rd_valid)
            diff_q <= diff_c;          // always <= 0
    end

    exp_lut u_lut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_shift  (cfg_shift),
        .lut_wr     (lut_wr),
        .diff       (diff_q),
        .diff_valid (diff_valid),
        .exp_value  (odata),
        .exp_valid  (odata_valid)
    );

    exp_sum_accumulator u_acc (
        .clk          (clk),
        .rst_n        (rst_n),
        .exp_value    (odata),
        .exp_valid    (odata_valid),
        .max_value    (max_value),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: verilog/softmax_input_buffer.sv
// block buffer of the softmax stage that stores SM_NUM elements, tracks the max,
// then replays the block and holds busy until the block result goes out

`timescale 1ns/1ps
`include "softmax_defines.svh"

module softmax_input_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  softmax_pkg::fp_word_t idata,
    input  logic                  idata_valid,
    output softmax_pkg::fp_word_t rd_data,
    output logic                  rd_valid,
    output softmax_pkg::fp_word_t max_value,
    output logic                  busy
);

    softmax_pkg::fp_word_t mem [`SM_NUM];
    logic [`SM_PTR_W-1:0]  wr_ptr;
    logic [`SM_PTR_W:0]    seq_cnt;    // cycles since the last element; low bits address mem
    logic                  accept;
    logic                  last_in;
    logic                  seq_done;

    // true float order x > y
    function automatic logic fp_gt(input softmax_pkg::fp_fields_t x,
                                   input softmax_pkg::fp_fields_t y);
        logic mag_gt;
        logic mag_lt;
        mag_gt = {x.exponent, x.mantissa} > {y.exponent, y.mantissa};
        mag_lt = {x.exponent, x.mantissa} < {y.exponent, y.mantissa};
        if (x.sign != y.sign)
            return y.sign;           // positive beats negative
        else if (x.sign)
            return mag_lt;           // both negative, smaller magnitude wins
        else
            return mag_gt;
    endfunction

    assign accept   = idata_valid && !busy;              // dropped while busy
    assign last_in  = accept && (wr_ptr == `SM_PTR_W'(`SM_NUM - 1));
    assign seq_done = busy && (seq_cnt == (`SM_PTR_W+1)'(`SM_NUM + 3));

    ////////////////////////////////////////////////////////////////////////////
    // fill side
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wr_ptr <= '0;
        else if (accept)
            wr_ptr <= wr_ptr + 1'b1;   // wraps to 0 after the last element
    end

    always_ff @(posedge clk) begin
        if (accept)
            mem[wr_ptr] <= idata;
        // first element seeds the max
        if (accept && (wr_ptr == '0 || fp_gt(idata.fields, max_value.fields)))
            max_value <= idata;
    end

    ////////////////////////////////////////////////////////////////////////////
    // replay and busy window
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            seq_cnt <= '0;
        end else if (last_in) begin
            busy    <= 1'b1;
            seq_cnt <= '0;
        end else if (busy) begin
            seq_cnt <= seq_cnt + 1'b1;
            if (seq_done)
                busy <= 1'b0;          // same edge as result_valid
        end
    end

    // registered replay of the first SM_NUM busy cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_valid <= 1'b0;
        else
            rd_valid <= busy && !seq_cnt[`SM_PTR_W];
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[seq_cnt[`SM_PTR_W-1:0]];
    end

endmodule

// File: verilog/softmax_pkg.sv
// types shared by the softmax exponent stage and its testbench
// refer to them as softmax_pkg::name

`include "softmax_defines.svh"

package softmax_pkg;

    // field view of a float word
    typedef struct packed {
        logic                 sign;
        logic [`SM_EXP_W-1:0] exponent;
        logic [`SM_MAN_W-1:0] mantissa;   // bit 8 is the leading one, 0 means zero
    } fp_fields_t;

    // raw bits for storage, fields for compare and arithmetic
    typedef union packed {
        logic [`SM_FP_W-1:0] raw;
        fp_fields_t          fields;
    } fp_word_t;

    // table write port
    typedef struct packed {
        logic                      en;
        logic [`SM_LUT_ADDR_W-1:0] addr;
        fp_word_t                  data;
    } lut_wr_t;

    // per block result
    typedef struct packed {
        fp_word_t sum;    // sum of the block's exponents
        fp_word_t max;    // block maximum
    } block_result_t;

endpackage
